//--- Bender.yml
package:
  name: ppu_rde

sources:
  - files:
      - logic/ppu_timing_pkg.sv
      - logic/ppu_vram_pkg.sv
      - logic/ppu_scan_if.sv
      - logic/ppu_scan_timer.sv
      - logic/ppu_tile_fetch.sv
      - logic/ppu_bg_shifter.sv
      - logic/ppu_vbuf_writer.sv
      - logic/ppu_rde_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_ppu_rde.sv

//--- filelist.f
+incdir+tb
logic/ppu_timing_pkg.sv
logic/ppu_vram_pkg.sv
logic/ppu_scan_if.sv
logic/ppu_scan_timer.sv
logic/ppu_tile_fetch.sv
logic/ppu_bg_shifter.sv
logic/ppu_vbuf_writer.sv
logic/ppu_rde_top.sv
tb/tb_ppu_rde.sv

//--- logic/ppu_bg_shifter.sv
`timescale 1ns/100ps

module ppu_bg_shifter (
    input  logic                    i_clk,
    input  logic                    i_rstn,
    ppu_scan_if.consumer            scan,
    input  logic [7:0]              i_ppumask,
    input  ppu_vram_pkg::pt_word_t  i_pt_rdata,
    input  ppu_vram_pkg::nt_rdata_u i_nt_rdata,
    input  logic [1:0]              i_attr_quad,
    input  logic [2:0]              i_fine_x,
    output ppu_vram_pkg::plt_idx_t  o_plt_addr
);
    import ppu_vram_pkg::*;

    // index 3..0 is attr hi, attr lo, plane 1, plane 0
    logic [3:0][15:0] r_shft;
    logic [3:0][7:0]  c_load_byte;
    logic [1:0]       c_attr;
    logic             c_load;
    logic             c_bg_ena;
    logic             c_bg_clip;
    logic             c_hide;
    plt_idx_t         c_pixel;

    assign c_bg_ena  = i_ppumask[3];
    assign c_bg_clip = i_ppumask[1];   // low hides the left 8 pixels
    assign c_load    = (scan.scan_x[2:0] == 3'd7);

    ////////////////////////////////////////
    // shift registers
    ////////////////////////////////////////

    assign c_attr         = i_nt_rdata.quad[i_attr_quad];
    assign c_load_byte[3] = {8{c_attr[1]}};
    assign c_load_byte[2] = {8{c_attr[0]}};
    assign c_load_byte[1] = i_pt_rdata[15:8];
    assign c_load_byte[0] = i_pt_rdata[7:0];

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_shft <= '0;
        end else if (scan.pixel_calc) begin
            for (int i = 0; i < 4; i++) begin
                if (c_load)
                    r_shft[i] <= {r_shft[i][14:7], c_load_byte[i]};  // shift and refill
                else
                    r_shft[i] <= {r_shft[i][14:0], 1'b0};
            end
        end
    end

    ////////////////////////////////////////
    // pixel select
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            c_pixel[i] = r_shft[i][15 - i_fine_x];  // fine x picks the tap
        end
    end

    assign c_hide     = !c_bg_ena || (!c_bg_clip && (scan.scan_x < 9'd8));
    assign o_plt_addr = c_hide ? plt_idx_t'(0) : c_pixel;

endmodule

//--- logic/ppu_rde_top.sv
`timescale 1ns/100ps

module ppu_rde_top #(
    parameter int LINE_CYCLES = 272
) (
    input  logic                                  i_clk,
    input  logic                                  i_rstn,
    // configuration
    input  logic [5:0]                            i_ppuctrl,
    input  logic [7:0]                            i_ppumask,
    input  logic [7:0]                            i_ppuscroll_x,
    input  logic [7:0]                            i_ppuscroll_y,
    input  logic                                  i_vblank,
    // video memories
    output logic [ppu_vram_pkg::NT_ADDR_W-1:0]    o_nt_addr,
    input  logic [7:0]                            i_nt_rdata,
    output logic [ppu_vram_pkg::PT_ADDR_W-1:0]    o_pt_addr,
    input  logic [15:0]                           i_pt_rdata,
    output logic [3:0]                            o_plt_addr,
    input  logic [7:0]                            i_plt_rdata,
    // frame buffer
    output logic [ppu_vram_pkg::VBUF_ADDR_W-1:0]  o_vbuf_addr,
    output logic                                  o_vbuf_we,
    output logic [7:0]                            o_vbuf_wdata
);

    logic [2:0] c_fine_x;
    logic [1:0] c_attr_quad;

    ppu_scan_if scan_if ();

    ppu_scan_timer #(
        .LINE_CYCLES (LINE_CYCLES)
    ) i_scan_timer (
        .i_clk    (i_clk),
        .i_rstn   (i_rstn),
        .i_vblank (i_vblank),
        .scan     (scan_if.timer)
    );

    ppu_tile_fetch #(
        .LINE_CYCLES (LINE_CYCLES)
    ) i_tile_fetch (
        .i_clk         (i_clk),
        .i_rstn        (i_rstn),
        .scan          (scan_if.consumer),
        .i_ppuctrl     (i_ppuctrl),
        .i_ppuscroll_x (i_ppuscroll_x),
        .i_ppuscroll_y (i_ppuscroll_y),
        .i_nt_rdata    (i_nt_rdata),
        .o_nt_addr     (o_nt_addr),
        .o_pt_addr     (o_pt_addr),
        .o_fine_x      (c_fine_x),
        .o_attr_quad   (c_attr_quad)
    );

    ppu_bg_shifter i_bg_shifter (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .scan        (scan_if.consumer),
        .i_ppumask   (i_ppumask),
        .i_pt_rdata  (i_pt_rdata),
        .i_nt_rdata  (i_nt_rdata),   // attribute byte at phase 7
        .i_attr_quad (c_attr_quad),
        .i_fine_x    (c_fine_x),
        .o_plt_addr  (o_plt_addr)
    );

    ppu_vbuf_writer i_vbuf_writer (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .scan         (scan_if.consumer),
        .i_plt_rdata  (i_plt_rdata),
        .o_vbuf_addr  (o_vbuf_addr),
        .o_vbuf_we    (o_vbuf_we),
        .o_vbuf_wdata (o_vbuf_wdata)
    );

endmodule

//--- logic/ppu_scan_if.sv
`timescale 1ns/100ps

interface ppu_scan_if;
    import ppu_timing_pkg::*;

    scan_pos_t scan_x;       // pixel cycle within the line
    scan_pos_t scan_y;       // line number
    logic      pixel_calc;   // shifters run, fetches active
    logic      line_end;     // last cycle of a line
    logic      preload;      // line_end of line 260
    logic      frame_start;  // synchronised vblank edge
    logic      page;         // frame-buffer page being drawn

    modport timer (
        output scan_x,
        output scan_y,
        output pixel_calc,
        output line_end,
        output preload,
        output frame_start,
        output page
    );

    modport consumer (
        input scan_x,
        input scan_y,
        input pixel_calc,
        input line_end,
        input preload,
        input frame_start,
        input page
    );

endinterface

//--- logic/ppu_scan_timer.sv
`timescale 1ns/100ps

module ppu_scan_timer #(
    parameter int LINE_CYCLES = 272
) (
    input  logic      i_clk,
    input  logic      i_rstn,
    input  logic      i_vblank,
    ppu_scan_if.timer scan
);
    import ppu_timing_pkg::*;

    localparam scan_pos_t X_LAST = scan_pos_t'(LINE_CYCLES - 1);

    logic      r_vblank;
    logic      rr_vblank;
    logic      rrr_vblank;
    logic      r_run;
    scan_pos_t r_x;
    scan_pos_t r_y;
    logic      r_page;

    ////////////////////////////////////////
    // vblank sync and frame start
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_vblank   <= 1'b0;
            rr_vblank  <= 1'b0;
            rrr_vblank <= 1'b0;
        end else begin
            r_vblank   <= i_vblank;
            rr_vblank  <= r_vblank;    // second sync stage
            rrr_vblank <= rr_vblank;   // edge history
        end
    end

    assign scan.frame_start = rr_vblank & ~rrr_vblank;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_run  <= 1'b0;
            r_page <= 1'b0;
        end else begin
            if (scan.frame_start) begin
                r_run  <= 1'b1;
                r_page <= ~r_page;     // first frame draws page 1
            end else if (scan.line_end && r_y == SCAN_Y_VISIBLE - 1) begin
                r_run  <= 1'b0;        // frame done after line 239
            end
        end
    end

    ////////////////////////////////////////
    // line and pixel counters
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_x <= '0;
            r_y <= SCAN_Y_START;
        end else if (scan.frame_start) begin
            r_x <= '0;
            r_y <= SCAN_Y_START;
        end else if (r_run) begin
            if (scan.line_end) begin
                r_x <= '0;
                r_y <= (r_y == SCAN_Y_LAST) ? scan_pos_t'(0) : r_y + 1'b1;
            end else begin
                r_x <= r_x + 1'b1;
            end
        end
    end

    assign scan.scan_x     = r_x;
    assign scan.scan_y     = r_y;
    assign scan.page       = r_page;
    assign scan.line_end   = r_run && (r_x == X_LAST);
    assign scan.preload    = scan.line_end && (r_y == SCAN_Y_PRELOAD);
    assign scan.pixel_calc = r_run && (r_x < SCAN_X_VISIBLE)
                          && ((r_y < SCAN_Y_VISIBLE) || (r_y == SCAN_Y_LAST));

    ap_x_range: assert property (@(posedge i_clk) disable iff (!i_rstn)
        r_x < LINE_CYCLES);

    // a new vblank must not cut into a running frame
    ap_no_restart: assert property (@(posedge i_clk) disable iff (!i_rstn)
        scan.frame_start |-> !r_run);

endmodule

//--- logic/ppu_tile_fetch.sv
`timescale 1ns/100ps

module ppu_tile_fetch #(
    parameter int LINE_CYCLES = 272
) (
    input  logic                                i_clk,
    input  logic                                i_rstn,
    ppu_scan_if.consumer                        scan,
    input  logic [5:0]                          i_ppuctrl,
    input  logic [7:0]                          i_ppuscroll_x,
    input  logic [7:0]                          i_ppuscroll_y,
    input  ppu_vram_pkg::nt_rdata_u             i_nt_rdata,
    output logic [ppu_vram_pkg::NT_ADDR_W-1:0]  o_nt_addr,
    output logic [ppu_vram_pkg::PT_ADDR_W-1:0]  o_pt_addr,
    output logic [2:0]                          o_fine_x,
    output logic [1:0]                          o_attr_quad
);
    import ppu_timing_pkg::*;
    import ppu_vram_pkg::*;

    localparam scan_pos_t X_LAST = scan_pos_t'(LINE_CYCLES - 1);

    logic [4:0] r_col;       // coarse column of the next fetch
    logic [4:0] r_row;       // coarse row
    logic [2:0] r_fine_y;
    logic [2:0] r_fine_x;
    logic [1:0] r_nt_base;   // {vertical, horizontal} table
    logic       r_base_x;    // horizontal table at line start

    logic       c_step_col;
    logic       c_last_slot;
    logic       c_fetch_tile;
    logic       c_fetch_attr;
    logic [9:0] c_attr_addr;

    assign c_step_col   = scan.pixel_calc && (scan.scan_x[2:0] == 3'd4);
    assign c_last_slot  = (scan.scan_x[7:3] == 5'd30);  // tile 0 of the next line
    assign c_fetch_tile = scan.pixel_calc && (scan.scan_x[2:0] == 3'd5);
    assign c_fetch_attr = scan.pixel_calc && (scan.scan_x[2:0] == 3'd6);

    ////////////////////////////////////////
    // scroll position
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_col     <= '0;
            r_row     <= '0;
            r_fine_y  <= '0;
            r_fine_x  <= '0;
            r_nt_base <= '0;
            r_base_x  <= 1'b0;
        end else if (scan.preload) begin
            r_col             <= i_ppuscroll_x[7:3] + 5'd1;  // slot 0 of line 261 steps first
            r_fine_x          <= i_ppuscroll_x[2:0];
            {r_row, r_fine_y} <= i_ppuscroll_y - 8'd1;       // stepped at slot 30 of line 261
            r_nt_base         <= i_ppuctrl[1:0];
            r_base_x          <= i_ppuctrl[0];
        end else if (c_step_col) begin
            r_col <= r_col + 5'd1;
            if (c_last_slot)
                r_nt_base[0] <= r_base_x;                    // back to the left edge table
            else if (r_col == 5'd31)
                r_nt_base[0] <= ~r_nt_base[0];               // into the horizontal neighbour

            if (c_last_slot) begin
                r_fine_y <= r_fine_y + 3'd1;
                if (r_fine_y == 3'd7) begin
                    if (r_row == 5'd29) begin
                        r_row        <= '0;
                        r_nt_base[1] <= ~r_nt_base[1];       // into the vertical neighbour
                    end else begin
                        r_row <= r_row + 5'd1;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // memory addresses
    ////////////////////////////////////////

    assign c_attr_addr = ATTR_ROW_BASE + {r_row[4:2], r_col[4:2]};

    always_comb begin
        o_nt_addr = '0;
        if (c_fetch_tile)
            o_nt_addr = {r_nt_base, r_row, r_col};
        else if (c_fetch_attr)
            o_nt_addr = {r_nt_base, c_attr_addr};
    end

    // tile index answers the phase 5 read
    assign o_pt_addr = c_fetch_attr ? {i_ppuctrl[4], i_nt_rdata.tile, r_fine_y} : '0;

    assign o_fine_x    = r_fine_x;
    assign o_attr_quad = {r_row[1], r_col[1]};  // bottom, right

    ap_pt_after_tile: assert property (@(posedge i_clk) disable iff (!i_rstn)
        (o_pt_addr != '0) |-> (scan.scan_x[2:0] == 3'd6) && $past(c_fetch_tile));

    // scroll must be in place before the prefetch on line 261
    ap_preload_slot: assert property (@(posedge i_clk) disable iff (!i_rstn)
        scan.preload |-> (scan.scan_x == X_LAST)
                         ##1 (scan.scan_y == SCAN_Y_LAST && scan.scan_x == '0));

endmodule

//--- logic/ppu_timing_pkg.sv
package ppu_timing_pkg;

    ////////////////////////////////////////
    // scan geometry
    ////////////////////////////////////////

    typedef logic [8:0] scan_pos_t;                 // line or pixel coordinate

    localparam scan_pos_t SCAN_Y_VISIBLE = 9'd240;  // lines 0..239 reach the frame buffer
    localparam scan_pos_t SCAN_Y_START   = 9'd240;  // counter lands here after vblank
    localparam scan_pos_t SCAN_Y_PRELOAD = 9'd260;  // scroll latched at end of this line
    localparam scan_pos_t SCAN_Y_LAST    = 9'd261;  // pre-render line, prefetches line 0

    localparam scan_pos_t SCAN_X_VISIBLE = 9'd256;  // pixel cycles per line

endpackage

//--- logic/ppu_vbuf_writer.sv
`timescale 1ns/100ps

module ppu_vbuf_writer (
    input  logic                                  i_clk,
    input  logic                                  i_rstn,
    ppu_scan_if.consumer                          scan,
    input  logic [7:0]                            i_plt_rdata,
    output logic [ppu_vram_pkg::VBUF_ADDR_W-1:0]  o_vbuf_addr,
    output logic                                  o_vbuf_we,
    output logic [7:0]                            o_vbuf_wdata
);
    import ppu_timing_pkg::*;

    scan_pos_t r_x1;
    scan_pos_t r_y1;
    scan_pos_t r_x2;
    scan_pos_t r_y2;
    logic      r_vis1;
    logic      r_vis2;
    logic      c_vis;

    assign c_vis = scan.pixel_calc && (scan.scan_y < SCAN_Y_VISIBLE);  // skips line 261

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_vis1 <= 1'b0;
            r_vis2 <= 1'b0;
        end else begin
            r_vis1 <= c_vis;    // palette read in flight
            r_vis2 <= r_vis1;   // write stage
        end
    end

    always_ff @(posedge i_clk) begin
        r_x1         <= scan.scan_x;
        r_y1         <= scan.scan_y;
        r_x2         <= r_x1;
        r_y2         <= r_y1;
        o_vbuf_wdata <= i_plt_rdata;
    end

    assign o_vbuf_we   = r_vis2;
    assign o_vbuf_addr = {scan.page, r_y2[7:0], r_x2[7:0]};

    ap_we_visible: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_vbuf_we |-> (r_x2 < SCAN_X_VISIBLE) && (r_y2 < SCAN_Y_VISIBLE)
                      && $past(scan.pixel_calc, 2));

endmodule

//--- logic/ppu_vram_pkg.sv
package ppu_vram_pkg;

    ////////////////////////////////////////
    // memory map
    ////////////////////////////////////////

    localparam int NT_ADDR_W   = 12;  // four 1 KB nametables
    localparam int PT_ADDR_W   = 12;  // {table sel, tile, fine row}
    localparam int VBUF_ADDR_W = 17;  // {page, y, x}

    // attribute bytes follow the 30x32 tile entries of each table
    localparam logic [9:0] ATTR_ROW_BASE = 10'd960;

    ////////////////////////////////////////
    // data words
    ////////////////////////////////////////

    typedef logic [15:0] pt_word_t;  // high byte plane 1, low byte plane 0
    typedef logic [3:0]  plt_idx_t;  // {attr hi, attr lo, plane 1, plane 0}

    // the nametable bus returns a tile index at phase 6
    // and an attribute byte at phase 7 of every tile slot
    typedef union packed {
        logic [7:0]      tile;  // tile index
        logic [3:0][1:0] quad;  // tl, tr, bl, br from the low bits
    } nt_rdata_u;

endpackage

//--- tb/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

////////////////////////////////////////
// video memories
////////////////////////////////////////

logic [7:0]  nt_mem  [0:4095];  // four nametables with their attribute blocks
logic [15:0] pt_mem  [0:4095];  // {table, tile, fine row}
logic [7:0]  plt_mem [0:15];

task automatic fill_memories();
    int a;

    for (a = 0; a < 4096; a++) begin
        nt_mem[a] = 8'($urandom);
        pt_mem[a] = 16'($urandom);
    end
    for (a = 0; a < 16; a++) begin
        plt_mem[a] = 8'($urandom);
    end
endtask

////////////////////////////////////////
// reference pixel
////////////////////////////////////////

function automatic logic [3:0] ref_bg_index(
    input int         x,
    input int         y,
    input logic [5:0] ctrl,
    input logic [7:0] mask,
    input logic [7:0] sx,
    input logic [7:0] sy
);
    int          pos;
    int          col;
    int          row;
    int          vt;
    int          nt_sel;
    int          tcol;
    int          trow;
    int          quad;
    int          bitn;
    logic [7:0]  tile;
    logic [7:0]  attr;
    logic [15:0] pat;

    if (!mask[3] || (x < 8 && !mask[1])) begin
        return 4'd0;                                  // background off or clipped
    end
    // 32 tiles are fetched per line; fine-x positions past the last one
    // run into the first tile prefetched for the next line
    pos = int'(sx[2:0]) + x;
    row = int'(sy) + y;
    if (pos >= 256) begin
        pos = pos - 256;
        row = row + 1;
    end
    col = ((ctrl[0] ? 256 : 0) + int'({sx[7:3], 3'b000}) + pos) % 512;
    vt  = ctrl[1] ? 1 : 0;
    if (row >= 240) begin
        row = row - 240;
        vt  = 1 - vt;                                 // into the vertical neighbour
    end
    nt_sel = vt * 2 + col / 256;
    tcol   = (col % 256) / 8;
    trow   = row / 8;
    tile   = nt_mem[nt_sel * 1024 + trow * 32 + tcol];
    attr   = nt_mem[nt_sel * 1024 + 960 + (row / 32) * 8 + tcol / 4];
    quad   = ((trow / 2) % 2) * 2 + (tcol / 2) % 2;  // bottom, right
    pat    = pt_mem[(ctrl[4] ? 2048 : 0) + int'(tile) * 8 + row % 8];
    bitn   = 7 - col % 8;
    return {attr[2 * quad +: 2], pat[8 + bitn], pat[bitn]};
endfunction

function automatic logic [7:0] ref_colour(
    input int         x,
    input int         y,
    input logic [5:0] ctrl,
    input logic [7:0] mask,
    input logic [7:0] sx,
    input logic [7:0] sy
);
    return plt_mem[ref_bg_index(x, y, ctrl, mask, sx, sy)];
endfunction

`endif

//--- tb/tb_ppu_rde.sv
`timescale 1ns/100ps

module tb_ppu_rde;

    localparam int LINE_CYCLES  = 272;
    localparam int NUM_FRAMES   = 5;
    localparam int FRAME_PIXELS = 240 * 256;
    localparam int CYCLE_LIMIT  = NUM_FRAMES * 262 * LINE_CYCLES + 10000;

    logic        i_clk;
    logic        i_rstn;
    logic [5:0]  i_ppuctrl;
    logic [7:0]  i_ppumask;
    logic [7:0]  i_ppuscroll_x;
    logic [7:0]  i_ppuscroll_y;
    logic        i_vblank;
    logic [11:0] o_nt_addr;
    logic [7:0]  i_nt_rdata;
    logic [11:0] o_pt_addr;
    logic [15:0] i_pt_rdata;
    logic [3:0]  o_plt_addr;
    logic [7:0]  i_plt_rdata;
    logic [16:0] o_vbuf_addr;
    logic        o_vbuf_we;
    logic [7:0]  o_vbuf_wdata;

    `include "tb_frame_model.svh"

    logic        exp_page;
    logic        expect_writes;
    int          write_count;
    int          cycle_count = 0;
    int unsigned seed_ret;
    bit          seen [0:65535];        // addresses written this frame
    string       frame_name;
    logic [11:0] nt_addr_q;
    logic [11:0] pt_addr_q;
    logic [3:0]  plt_addr_q;

    ppu_rde_top #(
        .LINE_CYCLES (LINE_CYCLES)
    ) i_ppu_rde_top (
        .i_clk         (i_clk),
        .i_rstn        (i_rstn),
        .i_ppuctrl     (i_ppuctrl),
        .i_ppumask     (i_ppumask),
        .i_ppuscroll_x (i_ppuscroll_x),
        .i_ppuscroll_y (i_ppuscroll_y),
        .i_vblank      (i_vblank),
        .o_nt_addr     (o_nt_addr),
        .i_nt_rdata    (i_nt_rdata),
        .o_pt_addr     (o_pt_addr),
        .i_pt_rdata    (i_pt_rdata),
        .o_plt_addr    (o_plt_addr),
        .i_plt_rdata   (i_plt_rdata),
        .o_vbuf_addr   (o_vbuf_addr),
        .o_vbuf_we     (o_vbuf_we),
        .o_vbuf_wdata  (o_vbuf_wdata)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic check_equal(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error %s expected %0h actual %0h", test, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch in %s", test);
        end
    endtask

    ////////////////////////////////////////
    // memories and write checker
    ////////////////////////////////////////

    always @(negedge i_clk) begin
        nt_addr_q  = o_nt_addr;     // address of the cycle now ending
        pt_addr_q  = o_pt_addr;
        plt_addr_q = o_plt_addr;
    end

    always @(posedge i_clk) begin
        #1;
        i_nt_rdata  = nt_mem[nt_addr_q];
        i_pt_rdata  = pt_mem[pt_addr_q];
        i_plt_rdata = plt_mem[plt_addr_q];
    end

    always @(negedge i_clk) begin : write_check
        int    x;
        int    y;
        string tag;

        x = int'(o_vbuf_addr[7:0]);
        y = int'(o_vbuf_addr[15:8]);
        if (!expect_writes) begin
            check_equal({frame_name, " idle write enable"}, 32'd0, o_vbuf_we);
        end else if (o_vbuf_we) begin
            tag = $sformatf("%s x=%0d y=%0d", frame_name, x, y);
            check_equal({tag, " page"}, exp_page, o_vbuf_addr[16]);
            check_equal({tag, " row range"}, 32'd1, y < 240);
            check_equal({tag, " repeat write"}, 32'd0, seen[o_vbuf_addr[15:0]]);
            seen[o_vbuf_addr[15:0]] = 1'b1;
            write_count = write_count + 1;
            check_equal({tag, " colour"}, ref_colour(x, y, i_ppuctrl, i_ppumask,
                        i_ppuscroll_x, i_ppuscroll_y), o_vbuf_wdata);
        end
    end

    always @(posedge i_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: frame writes did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    ////////////////////////////////////////
    // frame driver
    ////////////////////////////////////////

    task automatic run_frame(input int f);
        int a;

        @(posedge i_clk);
        #1;
        i_ppuctrl     = 6'($urandom);
        i_ppumask     = 8'($urandom) | 8'h0a;     // background on, left column shown
        i_ppuscroll_x = 8'($urandom);
        i_ppuscroll_y = 8'($urandom % 240);
        case (f)
            0: frame_name = "random_scroll";
            1: begin
                frame_name = "bg_disabled";
                i_ppumask  = i_ppumask & 8'hf7;
            end
            2: begin
                frame_name = "clip_off";
                i_ppumask  = i_ppumask & 8'hfd;
            end
            3: begin
                frame_name    = "table_cross";     // both table wraps inside the frame
                i_ppuctrl     = i_ppuctrl | 6'h03;
                i_ppuscroll_x = 8'hc0 | 8'($urandom % 64);
                i_ppuscroll_y = 8'(200 + $urandom % 40);
            end
            default: begin
                frame_name = "random_mixed";
                i_ppumask  = 8'($urandom);
            end
        endcase
        for (a = 0; a < 65536; a++) begin
            seen[a] = 1'b0;
        end
        write_count   = 0;
        exp_page      = ~exp_page;
        expect_writes = 1'b1;
        i_vblank      = 1'b1;
        repeat (4) @(posedge i_clk);
        #1 i_vblank = 1'b0;
        while (write_count < FRAME_PIXELS) begin
            @(posedge i_clk);
        end
        expect_writes = 1'b0;                    // any later write is an error
        repeat (LINE_CYCLES) @(posedge i_clk);
    endtask

    initial begin : main
        int f;

        seed_ret      = $urandom(32'h7480);
        i_rstn        = 1'b0;
        i_vblank      = 1'b0;
        i_ppuctrl     = '0;
        i_ppumask     = '0;
        i_ppuscroll_x = '0;
        i_ppuscroll_y = '0;
        i_nt_rdata    = '0;
        i_pt_rdata    = '0;
        i_plt_rdata   = '0;
        exp_page      = 1'b0;
        expect_writes = 1'b0;
        write_count   = 0;
        frame_name    = "reset";
        fill_memories();
        repeat (8) @(posedge i_clk);
        #1 i_rstn = 1'b1;
        frame_name = "before_vblank";
        repeat (200) @(posedge i_clk);           // idle, no frame started
        for (f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule
